/* common/cpu_bus_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU bus as seen by the glue logic
// modports for the address decoder and the controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface cpu_bus_if import main_map_pkg::*; ();

    logic [addr_w-1:0] addr;
    logic              rnw;        // 1 = read
    logic              vma;        // valid memory address
    logic [data_w-1:0] dout;       // CPU write data
    logic              cpu_cen;    // one clock per bus cycle, last clock

    // rom only answers reads, so rnw goes to the decoder too
    modport decoder (
        input addr,
        input rnw,
        input vma
    );

    modport ctrl (
        input addr,
        input rnw,
        input dout,
        input cpu_cen
    );

endinterface

/* common/main_io_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cabinet and control definitions
// cabinet read page enum, control latch bit enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package main_io_pkg;

    // read page on addr[1:0] of the ior port
    typedef enum logic [1:0] {
        page_sys  = 2'd0,   // jumpers, starts, service, coins
        page_p1   = 2'd1,
        page_p2   = 2'd2,
        page_dipa = 2'd3
    } cab_page_e;

    // addressable latch, bit select on addr[2:0]
    // data bit 0 is the value written
    typedef enum logic [2:0] {
        lat_flip    = 3'd0,     // screen flip
        lat_snd_irq = 3'd1,     // sound CPU interrupt line
        lat_irq_clr = 3'd7      // 0 holds the vblank irq clear
    } latch_bit_e;

    // bits 2..6 drive counters and test outputs on the board,
    // nothing here listens to them

endpackage

/* common/main_map_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU address map
// bus widths, decoded region enum, bank and I/O sub-port numbers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package main_map_pkg;

    localparam int addr_w = 16;     // 6809 address bus
    localparam int data_w = 8;

    // one value per chip select or port seen by the CPU
    typedef enum logic [3:0] {
        reg_none   = 4'd0,
        reg_rom    = 4'd1,
        reg_vram   = 4'd2,
        reg_ram    = 4'd3,
        reg_objram = 4'd4,
        reg_intst  = 4'd5,          // interrupt status, toggles object frame
        reg_iow    = 4'd6,          // control latch
        reg_snd    = 4'd7,          // sound latch
        reg_in5    = 4'd8,          // dip bank b
        reg_ior    = 4'd9           // cabinet pages
    } region_e;

    // 8 kB banks on addr[15:13]
    localparam logic [2:0] bank_low = 3'd0;     // object RAM and I/O
    localparam logic [2:0] bank_vid = 3'd1;     // video and work RAM

    // 1 kB sub-blocks of the low bank, addr[12:10]
    localparam logic [2:0] sub_objram = 3'd4;
    localparam logic [2:0] sub_io     = 3'd5;

    // I/O ports on addr[9:7]
    localparam logic [2:0] port_intst = 3'd0;
    localparam logic [2:0] port_iow   = 3'd1;
    localparam logic [2:0] port_snd   = 3'd2;
    localparam logic [2:0] port_in5   = 3'd4;
    localparam logic [2:0] port_ior   = 3'd5;

endpackage

/* compile.f */
common/main_map_pkg.sv
common/main_io_pkg.sv
common/cpu_bus_if.sv
verilog/main_decoder.sv
verilog/cabinet_reader.sv
verilog/main_ctrl.sv
verilog/main_board.sv
verif/main_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the main board testbench with Verilator
# the log is searched for the fail message at the end
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module main_board_tb \
    -f compile.f \
    --Mdir obj_dir -o main_board_sim

./obj_dir/main_board_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation done"

/* verif/main_board_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the main CPU glue
// clock, reset, bus cycles from a stimulus table, irq sequence, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_board_tb import main_map_pkg::*, main_io_pkg::*; ();

    localparam logic rd = 1'b1;
    localparam logic wr = 1'b0;
    localparam logic [7:0] rom_byte  = 8'ha5;   // one pattern per source
    localparam logic [7:0] ram_byte  = 8'h3c;
    localparam logic [7:0] vram_byte = 8'h5a;
    localparam logic [7:0] obj_byte  = 8'hc3;

    logic        clk, rst, cpu_cen, rnw, vma;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, rom_data, ram_dout, vram_dout, obj_dout;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic        service, lvbl, dip_pause;
    logic [7:0]  dipsw_a, dipsw_b;
    logic [2:0]  dipsw_c;
    logic [7:0]  cpu_din;
    logic        rom_cs, ram_cs, vram_cs, objram_cs, snd_data_cs;
    logic        obj_frame, flip, snd_irq, irq_n;

    // stimulus table, one slot per entry in each queue
    string       t_name[$];
    logic [15:0] t_addr[$];
    logic        t_rnw[$];
    logic        t_vma[$];
    logic [7:0]  t_wdata[$];
    logic [4:0]  t_cs[$];       // rom, ram, vram, objram, snd
    region_e     t_region[$];   // picks the expected read source
    logic [2:0]  t_state[$];    // flip, snd_irq, obj_frame after the cycle

    logic [31:0] lcg_state = 32'd91930;
    int          errors = 0;
    int          checks = 0;
    int          table_len = 0;
    logic        table_ready = 1'b0;

    main_board dut0 (
        .clk (clk), .rst (rst), .cpu_cen (cpu_cen), .addr (addr), .rnw (rnw),
        .vma (vma), .cpu_dout (cpu_dout), .rom_data (rom_data), .ram_dout (ram_dout),
        .vram_dout (vram_dout), .obj_dout (obj_dout), .start_button (start_button),
        .coin_input (coin_input), .joystick1 (joystick1), .joystick2 (joystick2),
        .service (service), .lvbl (lvbl), .dip_pause (dip_pause), .dipsw_a (dipsw_a),
        .dipsw_b (dipsw_b), .dipsw_c (dipsw_c), .cpu_din (cpu_din), .rom_cs (rom_cs),
        .ram_cs (ram_cs), .vram_cs (vram_cs), .objram_cs (objram_cs),
        .snd_data_cs (snd_data_cs), .obj_frame (obj_frame), .flip (flip),
        .snd_irq (snd_irq), .irq_n (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // bank 0, I/O sub-block, port on addr[9:7]
    function automatic logic [15:0] io_addr(input logic [2:0] port, input logic [6:0] low);
        return {bank_low, sub_io, port, low};
    endfunction

    // top bit 1, buttons, then swapped direction pairs
    function automatic logic [7:0] player_byte(input logic [6:0] joy);
        return {1'b1, joy[6:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    function automatic logic [7:0] expected_read(input region_e r, input logic [1:0] low);
        case (r)
            reg_rom:    return rom_byte;
            reg_ram:    return ram_byte;
            reg_vram:   return vram_byte;
            reg_objram: return obj_byte;
            reg_in5:    return dipsw_b;
            reg_ior: begin
                case (cab_page_e'(low))
                    page_sys: return {dipsw_c, start_button, service, coin_input};
                    page_p1:  return player_byte(joystick1);
                    page_p2:  return player_byte(joystick2);
                    default:  return dipsw_a;
                endcase
            end
            default:    return 8'hff;   // nothing drives the bus
        endcase
    endfunction

    task automatic add_entry(input string name, input logic [15:0] a, input logic r,
                             input logic v, input logic [7:0] d, input logic [4:0] cs,
                             input region_e reg_exp, input logic [2:0] state);
        t_name.push_back(name);
        t_addr.push_back(a);
        t_rnw.push_back(r);
        t_vma.push_back(v);
        t_wdata.push_back(d);
        t_cs.push_back(cs);
        t_region.push_back(reg_exp);
        t_state.push_back(state);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [7:0] expected, input logic [7:0] actual);
        checks = checks + 1;
        assert (expected === actual) else begin
            errors = errors + 1;
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    // starts on a falling edge, four clocks, cpu_cen on the last
    task automatic bus_cycle(input logic [15:0] a, input logic r, input logic v,
                             input logic [7:0] d);
        addr     = a;
        rnw      = r;
        vma      = v;
        cpu_dout = d;
        cpu_cen  = 1'b0;
        repeat (3) @(negedge clk);
        cpu_cen = 1'b1;
        @(negedge clk);
        cpu_cen = 1'b0;
    endtask

    task automatic build_table();
        add_entry("rom_read_8000",  16'h8000, rd, 1'b1, 8'h00, 5'b10000, reg_rom,    3'b000);
        add_entry("rom_read_6000",  16'h6000, rd, 1'b1, 8'h00, 5'b10000, reg_rom,    3'b000);
        add_entry("rom_read_ffff",  16'hffff, rd, 1'b1, 8'h00, 5'b10000, reg_rom,    3'b000);
        add_entry("rom_write_8000", 16'h8000, wr, 1'b1, 8'h55, 5'b00000, reg_none,   3'b000);
        add_entry("bank2_read",     16'h4000, rd, 1'b1, 8'h00, 5'b00000, reg_none,   3'b000);
        add_entry("vram_read",      16'h2000, rd, 1'b1, 8'h00, 5'b00100, reg_vram,   3'b000);
        add_entry("scroll_ram",     16'h2020, rd, 1'b1, 8'h00, 5'b01000, reg_ram,    3'b000);
        add_entry("ram_read_3000",  16'h3000, rd, 1'b1, 8'h00, 5'b01000, reg_ram,    3'b000);
        add_entry("ram_read_3800",  16'h3800, rd, 1'b1, 8'h00, 5'b01000, reg_ram,    3'b000);
        add_entry("bank1_gap",      16'h2800, rd, 1'b1, 8'h00, 5'b00000, reg_none,   3'b000);
        add_entry("objram_read",    16'h1000, rd, 1'b1, 8'h00, 5'b00010, reg_objram, 3'b000);
        add_entry("bank0_gap",      16'h0800, rd, 1'b1, 8'h00, 5'b00000, reg_none,   3'b000);
        add_entry("vma_low",        16'h8000, rd, 1'b0, 8'h00, 5'b00000, reg_none,   3'b000);
        add_entry("in5_read",  io_addr(port_in5, 7'd0), rd, 1'b1, 8'h00, 5'b00000, reg_in5,
                  3'b000);
        add_entry("snd_write", io_addr(port_snd, 7'd0), wr, 1'b1, 8'h21, 5'b00001, reg_snd,
                  3'b000);
        add_entry("port3_read", io_addr(3'd3, 7'd0), rd, 1'b1, 8'h00, 5'b00000, reg_none,
                  3'b000);
        // cabinet pages on the low address bits
        add_entry("ior_sys",  io_addr(port_ior, 7'd0), rd, 1'b1, 8'h00, 5'b0, reg_ior, 3'b000);
        add_entry("ior_p1",   io_addr(port_ior, 7'd1), rd, 1'b1, 8'h00, 5'b0, reg_ior, 3'b000);
        add_entry("ior_p2",   io_addr(port_ior, 7'd2), rd, 1'b1, 8'h00, 5'b0, reg_ior, 3'b000);
        add_entry("ior_dipa", io_addr(port_ior, 7'd3), rd, 1'b1, 8'h00, 5'b0, reg_ior, 3'b000);
        // control latch, data bit 0 is the value
        add_entry("flip_set",    io_addr(port_iow, 7'(lat_flip)), wr, 1'b1, 8'h01, 5'b0,
                  reg_iow, 3'b100);
        add_entry("snd_irq_set", io_addr(port_iow, 7'(lat_snd_irq)), wr, 1'b1, 8'h01, 5'b0,
                  reg_iow, 3'b110);
        add_entry("iow_read",    io_addr(port_iow, 7'(lat_flip)), rd, 1'b1, 8'h00, 5'b0,
                  reg_iow, 3'b110);
        add_entry("latch_bit3",  io_addr(port_iow, 7'd3), wr, 1'b1, 8'h00, 5'b0,
                  reg_iow, 3'b110);
        add_entry("flip_clear",  io_addr(port_iow, 7'(lat_flip)), wr, 1'b1, 8'h00, 5'b0,
                  reg_iow, 3'b010);
        add_entry("snd_irq_clr", io_addr(port_iow, 7'(lat_snd_irq)), wr, 1'b1, 8'hfe, 5'b0,
                  reg_iow, 3'b000);
        // object frame, one toggle per run of intst cycles
        add_entry("intst_first", io_addr(port_intst, 7'd0), rd, 1'b1, 8'h00, 5'b0,
                  reg_intst, 3'b001);
        add_entry("intst_second", io_addr(port_intst, 7'd0), rd, 1'b1, 8'h00, 5'b0,
                  reg_intst, 3'b001);
        add_entry("ram_between", 16'h3000, rd, 1'b1, 8'h00, 5'b01000, reg_ram, 3'b001);
        add_entry("intst_again", io_addr(port_intst, 7'd0), rd, 1'b1, 8'h00, 5'b0,
                  reg_intst, 3'b000);
    endtask

    // stops a run that never reaches the end
    initial begin
        wait (table_ready);
        repeat (table_len * 4 + 200) @(posedge clk);
        $display("timeout: test sequence still running after %0d clocks", table_len * 4 + 200);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rst       = 1'b1;
        cpu_cen   = 1'b0;
        addr      = 16'h0000;
        rnw       = 1'b1;
        vma       = 1'b0;
        cpu_dout  = 8'h00;
        rom_data  = rom_byte;
        ram_dout  = ram_byte;
        vram_dout = vram_byte;
        obj_dout  = obj_byte;
        lvbl = 1'b1;
        dip_pause = 1'b1;
        r = next_random();
        joystick1    = r[22:16];
        joystick2    = r[30:24];
        start_button = r[9:8];
        coin_input   = r[11:10];
        service      = r[12];
        r = next_random();
        dipsw_a = r[23:16];
        dipsw_b = r[31:24];
        dipsw_c = r[14:12];
        build_table();
        table_len   = t_name.size();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("after_reset", "latch", 8'h00, {5'b0, flip, snd_irq, obj_frame});
        check_value("after_reset", "irq_n", 8'h01, {7'b0, irq_n});

        for (int i = 0; i < table_len; i++) begin
            bus_cycle(t_addr[i], t_rnw[i], t_vma[i], t_wdata[i]);
            check_value(t_name[i], "selects", {3'b000, t_cs[i]},
                        {3'b000, rom_cs, ram_cs, vram_cs, objram_cs, snd_data_cs});
            check_value(t_name[i], "cpu_din", expected_read(t_region[i], t_addr[i][1:0]),
                        cpu_din);
            check_value(t_name[i], "latch", {5'b0, t_state[i]}, {5'b0, flip, snd_irq, obj_frame});
        end

        // vblank with the clear bit still 0
        lvbl = 1'b0;
        repeat (3) @(negedge clk);
        check_value("irq_masked", "irq_n", 8'h01, {7'b0, irq_n});
        lvbl = 1'b1;
        bus_cycle(io_addr(port_iow, 7'(lat_irq_clr)), wr, 1'b1, 8'h01);
        check_value("irq_enable", "irq_n", 8'h01, {7'b0, irq_n});
        lvbl = 1'b0;                    // trigger edge, set one clock later
        repeat (2) @(negedge clk);
        check_value("irq_vblank", "irq_n", 8'h00, {7'b0, irq_n});
        lvbl = 1'b1;
        bus_cycle(io_addr(port_iow, 7'(lat_irq_clr)), wr, 1'b1, 8'h00);
        check_value("irq_cleared", "irq_n", 8'h01, {7'b0, irq_n});
        bus_cycle(io_addr(port_iow, 7'(lat_irq_clr)), wr, 1'b1, 8'h01);
        dip_pause = 1'b0;               // paused, no trigger
        lvbl = 1'b0;
        repeat (3) @(negedge clk);
        check_value("irq_paused", "irq_n", 8'h01, {7'b0, irq_n});
        lvbl = 1'b1;
        @(negedge clk);
        dip_pause = 1'b1;

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/cabinet_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cabinet input reader
// registers the selected page of coins, buttons, joysticks and DIPs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cabinet_reader import main_map_pkg::*, main_io_pkg::*; (
    input  logic              clk,
    input  cab_page_e         page,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic [6:0]        joystick1,
    input  logic [6:0]        joystick2,
    input  logic              service,
    input  logic [7:0]        dipsw_a,
    input  logic [2:0]        dipsw_c,       // board jumpers
    output logic [data_w-1:0] cabinet
);

    // player byte: top bit reads 1, buttons 6..4,
    // then the direction pairs swapped on the connector
    function automatic logic [data_w-1:0] pack_player(input logic [6:0] joy);
        pack_player = {1'b1, joy[6:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    // follows the address one clock later
    always_ff @(posedge clk) begin
        case (page)
            page_sys:  cabinet <= {dipsw_c, start_button, service, coin_input};
            page_p1:   cabinet <= pack_player(joystick1);
            page_p2:   cabinet <= pack_player(joystick2);
            page_dipa: cabinet <= dipsw_a;
        endcase
    end

endmodule

/* verilog/main_board.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU glue, top level
// CPU bus interface, decoder, cabinet reader and controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_board import main_map_pkg::*, main_io_pkg::*; #(
    parameter int rom_first_bank = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_cen,
    input  logic [addr_w-1:0] addr,
    input  logic              rnw,
    input  logic              vma,
    input  logic [data_w-1:0] cpu_dout,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_dout,
    input  logic [data_w-1:0] vram_dout,
    input  logic [data_w-1:0] obj_dout,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic [6:0]        joystick1,
    input  logic [6:0]        joystick2,
    input  logic              service,
    input  logic              lvbl,
    input  logic              dip_pause,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic [2:0]        dipsw_c,
    output logic [data_w-1:0] cpu_din,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              objram_cs,
    output logic              snd_data_cs,
    output logic              obj_frame,
    output logic              flip,
    output logic              snd_irq,
    output logic              irq_n
);

    cpu_bus_if         cpu_bus ();
    region_e           region;
    logic [data_w-1:0] cabinet;

    assign cpu_bus.addr    = addr;
    assign cpu_bus.rnw     = rnw;
    assign cpu_bus.vma     = vma;
    assign cpu_bus.dout    = cpu_dout;
    assign cpu_bus.cpu_cen = cpu_cen;

    main_decoder #(
        .rom_first_bank (rom_first_bank)
    ) u_decoder (
        .bus         (cpu_bus),
        .region      (region),
        .rom_cs      (rom_cs),
        .ram_cs      (ram_cs),
        .vram_cs     (vram_cs),
        .objram_cs   (objram_cs),
        .snd_data_cs (snd_data_cs)
    );

    cabinet_reader u_cabinet (
        .clk          (clk),
        .page         (cab_page_e'(addr[1:0])),    // low bits pick the page
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_c      (dipsw_c),
        .cabinet      (cabinet)
    );

    main_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .bus       (cpu_bus),
        .region    (region),
        .cabinet   (cabinet),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .vram_dout (vram_dout),
        .obj_dout  (obj_dout),
        .dipsw_b   (dipsw_b),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .cpu_din   (cpu_din),
        .flip      (flip),
        .snd_irq   (snd_irq),
        .obj_frame (obj_frame),
        .irq_n     (irq_n)
    );

endmodule

/* verilog/main_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU controller
// read data mux, control latch, object frame toggle, vblank irq
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_ctrl import main_map_pkg::*, main_io_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    cpu_bus_if.ctrl           bus,
    input  region_e           region,
    input  logic [data_w-1:0] cabinet,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_dout,
    input  logic [data_w-1:0] vram_dout,
    input  logic [data_w-1:0] obj_dout,
    input  logic [data_w-1:0] dipsw_b,
    input  logic              lvbl,         // low during vertical blank
    input  logic              dip_pause,    // low freezes the game
    output logic [data_w-1:0] cpu_din,
    output logic              flip,
    output logic              snd_irq,
    output logic              obj_frame,
    output logic              irq_n
);

    latch_bit_e latch_sel;
    logic       latch_we;
    logic       clr_write;      // bit 7 written with 0
    logic       irq_clr;        // latch bit 7, 0 = irq held clear
    logic       intst_l;        // intst seen on previous cpu_cen
    logic       irq_trigger;
    logic       trigger_l;
    logic       irq_ff;

    assign latch_sel   = latch_bit_e'(bus.addr[2:0]);
    assign latch_we    = bus.cpu_cen && region == reg_iow && !bus.rnw;
    assign clr_write   = latch_we && latch_sel == lat_irq_clr && !bus.dout[0];
    assign irq_trigger = ~lvbl & dip_pause;

    // read mux, registered every clock
    always_ff @(posedge clk) begin
        case (region)
            reg_rom:    cpu_din <= rom_data;
            reg_vram:   cpu_din <= vram_dout;
            reg_ram:    cpu_din <= ram_dout;
            reg_objram: cpu_din <= obj_dout;
            reg_ior:    cpu_din <= cabinet;
            reg_in5:    cpu_din <= dipsw_b;
            default:    cpu_din <= 8'hff;   // open bus
        endcase
    end

    // addressable latch and object frame
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
            irq_clr   <= 1'b0;
            obj_frame <= 1'b0;
            intst_l   <= 1'b0;
        end else begin
            if (bus.cpu_cen) begin
                intst_l <= region == reg_intst;
                // toggle once per run of intst cycles
                if (region == reg_intst && !intst_l) begin
                    obj_frame <= ~obj_frame;
                end
            end
            if (latch_we) begin
                case (latch_sel)
                    lat_flip:    flip    <= bus.dout[0];
                    lat_snd_irq: snd_irq <= bus.dout[0];
                    lat_irq_clr: irq_clr <= bus.dout[0];
                    default: ;  // counters, test pin
                endcase
            end
        end
    end

    // vblank irq, set on trigger rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            trigger_l <= 1'b0;
            irq_ff    <= 1'b0;
        end else begin
            trigger_l <= irq_trigger;
            if (!irq_clr || clr_write) begin
                irq_ff <= 1'b0;     // clear wins over a new edge
            end else if (irq_trigger && !trigger_l) begin
                irq_ff <= 1'b1;
            end
        end
    end

    assign irq_n = ~irq_ff;

    // irq line released in the same clock that bit 7 drops
    a_irq_masked : assert property (@(posedge clk) disable iff (rst)
        !irq_clr |-> irq_n)
        else $error("main_ctrl: irq_n low while the clear bit is 0");

    // bus cycle ends on a settled address
    a_cen_settled : assert property (@(posedge clk) disable iff (rst)
        bus.cpu_cen |-> $stable(bus.addr) && $stable(bus.rnw))
        else $error("main_ctrl: address or rnw moved on the cpu_cen clock");

endmodule

/* verilog/main_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU address decoder
// combinational region and chip selects from addr, rnw and vma
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_decoder import main_map_pkg::*; #(
    parameter int rom_first_bank = 3    // set by the ROM jumpers
) (
    cpu_bus_if.decoder bus,
    output region_e    region,
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       objram_cs,
    output logic       snd_data_cs
);

    logic [2:0] bank;
    logic       rom_hit;

    assign bank = bus.addr[15:13];

    always_comb begin
        region  = reg_none;
        // rom decoded on its own, as on the board
        rom_hit = bus.vma && bus.rnw && (int'(bank) >= rom_first_bank);
        if (bus.vma) begin
            if (bank == bank_vid) begin
                case (bus.addr[12:11])
                    2'd0: region = bus.addr[5] ? reg_ram : reg_vram; // half of scroll RAM
                    2'd2,
                    2'd3: region = reg_ram;     // 3 is battery backed
                    default: ;
                endcase
            end
            if (bank == bank_low) begin
                case (bus.addr[12:10])
                    sub_objram: region = reg_objram;
                    sub_io: begin
                        case (bus.addr[9:7])    // port decoder
                            port_intst: region = reg_intst;
                            port_iow:   region = reg_iow;
                            port_snd:   region = reg_snd;
                            port_in5:   region = reg_in5;
                            port_ior:   region = reg_ior;
                            default: ;          // 3, 6, 7 unused
                        endcase
                    end
                    default: ;
                endcase
            end
        end
        if (rom_hit && region == reg_none) begin
            region = reg_rom;
        end
    end

    assign rom_cs      = rom_hit;
    assign ram_cs      = region == reg_ram;
    assign vram_cs     = region == reg_vram;
    assign objram_cs   = region == reg_objram;
    assign snd_data_cs = region == reg_snd;

    // a low rom_first_bank would let ROM overlap the RAM banks
    always_comb begin
        assert ($onehot0({rom_cs, ram_cs, vram_cs, objram_cs, snd_data_cs}))
            else $error("main_decoder: more than one chip select at addr %h", bus.addr);
    end

endmodule
